/* bench/tb_calc_uart.sv */
// testbench for the uart calculator checking serial echo and results against a byte table
`timescale 1ns/1ps

module tb_calc_uart;

   localparam int CLKS_PER_BIT = 16;
   localparam int MAX_ROWS     = 64;
   localparam int BYTE_GAP     = uart_pkg::FRAME_BITS * CLKS_PER_BIT + 4;   // after a non-operator

   logic                        CLKOP;
   logic                        i_rst;
   logic                        i_rx_valid;
   logic [calc_pkg::CHAR_W-1:0] i_rx_data;
   logic                        o_serial_data;
   logic                        o_tx_busy;
   logic                        o_result_valid;
   logic [calc_pkg::CHAR_W-1:0] o_result_char;

   // ----------------------------------------------------------------------
   // stimulus table and scoreboard queues
   // ----------------------------------------------------------------------
   logic [7:0] row_char    [MAX_ROWS];   // byte sent
   logic       row_has_res [MAX_ROWS];   // result expected after this byte
   logic [7:0] row_res     [MAX_ROWS];   // expected result char
   int         num_rows = 0;

   logic [7:0] serial_q [$];             // bytes decoded from the line
   logic [7:0] result_q [$];             // o_result_char per o_result_valid

   int     error_cnt     = 0;
   int     pass_cnt      = 0;
   int     fail_cnt      = 0;
   int     cycle_cnt     = 0;
   int     timeout_limit = 0;            // set once the table is built
   integer seed;

   calc_uart_top #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) UUT (
      .CLKOP          (CLKOP),
      .i_rst          (i_rst),
      .i_rx_valid     (i_rx_valid),
      .i_rx_data      (i_rx_data),
      .o_serial_data  (o_serial_data),
      .o_tx_busy      (o_tx_busy),
      .o_result_valid (o_result_valid),
      .o_result_char  (o_result_char)
   );

   initial CLKOP = 1'b0;
   always #50 CLKOP = ~CLKOP;            // 100 ns period

   // result char is 010, then carry, then the 4-bit sum
   // for sub the carry is high when no borrow is needed
   function automatic logic [7:0] calc_result(input logic [3:0] a, input logic [3:0] b,
                                              input logic sub);
      int         total;
      logic       carry;
      logic [3:0] nib;
      if (sub) begin
         carry = (a >= b);
         total = int'(a) - int'(b) + 16;   // keep it positive for the modulo
      end else begin
         total = int'(a) + int'(b);
         carry = (total > 15);
      end
      nib = 4'(total % 16);
      return {3'b010, carry, nib};
   endfunction

   function automatic logic is_operator(input logic [7:0] c);
      return (c == calc_pkg::CHAR_PLUS) || (c == calc_pkg::CHAR_MINUS);
   endfunction

   task automatic add_row(input logic [7:0] c, input logic has_res, input logic [7:0] res);
      row_char[num_rows]    = c;
      row_has_res[num_rows] = has_res;
      row_res[num_rows]     = res;
      num_rows++;
   endtask

   task automatic compare_value(input string name, input logic [7:0] exp, input logic [7:0] got);
      assert (got === exp) else begin
         $display("MISMATCH %s exp %02h got %02h", name, exp, got);
         error_cnt++;
      end
   endtask

   task automatic expect_serial(input logic [7:0] exp);
      logic [7:0] got;
      assert (serial_q.size() > 0) else begin
         $display("no byte decoded from the serial line, expected %02h", exp);
         error_cnt++;
      end
      if (serial_q.size() > 0) begin
         got = serial_q.pop_front();
         compare_value("o_serial_data", exp, got);
      end
   endtask

   task automatic expect_result(input logic [7:0] exp);
      logic [7:0] got;
      assert (result_q.size() > 0) else begin
         $display("no o_result_valid pulse, expected result %02h", exp);
         error_cnt++;
      end
      if (result_q.size() > 0) begin
         got = result_q.pop_front();
         compare_value("o_result_char", exp, got);
      end
   endtask

   task automatic record_test(input string name, input int errs_before);
      if (error_cnt == errs_before) begin
         pass_cnt++;
         $display("test %s ok", name);
      end else begin
         fail_cnt++;
         $display("test %s failed", name);
      end
   endtask

   // ----------------------------------------------------------------------
   // serial decoder sampling mid-bit
   // ----------------------------------------------------------------------
   always begin : serial_decoder
      logic [7:0] data;
      @(posedge CLKOP);
      if (!i_rst && o_serial_data === 1'b0) begin
         repeat (CLKS_PER_BIT / 2) @(posedge CLKOP);   // middle of start bit
         assert (o_serial_data === 1'b0) else begin
            $display("start bit on the serial line did not last half a bit");
            error_cnt++;
         end
         if (o_serial_data === 1'b0) begin
            for (int n = 0; n < 8; n++) begin
               repeat (CLKS_PER_BIT) @(posedge CLKOP);
               data[n] = o_serial_data;                 // lsb first
            end
            repeat (CLKS_PER_BIT) @(posedge CLKOP);
            assert (o_serial_data === 1'b1) else begin
               $display("framing error, stop bit on the serial line is low");
               error_cnt++;
            end
            serial_q.push_back(data);
         end
      end
   end

   // result strobe monitor
   always @(posedge CLKOP) begin
      if (!i_rst && o_result_valid === 1'b1) begin
         result_q.push_back(o_result_char);
      end
   end

   // watchdog
   always @(posedge CLKOP) begin
      cycle_cnt = cycle_cnt + 1;
      if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
         $display("run timed out after %0d cycles", cycle_cnt);
         $display("TB FAILED");
         $finish;
      end
   end

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial begin : main
      int         gap;
      int         errs_before;
      logic [3:0] a;
      logic [3:0] b;
      seed       = 32'h59234460;
      i_rst      = 1'b1;
      i_rx_valid = 1'b0;
      i_rx_data  = '0;

      add_row("7", 1'b0, 8'h00);                     // fixed add and sub cases
      add_row("9", 1'b0, 8'h00);
      add_row("+", 1'b1, 8'h50);
      add_row("3", 1'b0, 8'h00);
      add_row("5", 1'b0, 8'h00);
      add_row("-", 1'b1, 8'h4E);                     // borrow so carry 0
      add_row("9", 1'b0, 8'h00);
      add_row("2", 1'b0, 8'h00);
      add_row("-", 1'b1, 8'h57);
      add_row("4", 1'b0, 8'h00);                     // esc after one digit
      add_row(calc_pkg::CHAR_ESC, 1'b0, 8'h00);
      add_row("1", 1'b0, 8'h00);                     // letter in digit slot
      add_row("A", 1'b0, 8'h00);
      add_row("2", 1'b0, 8'h00);                     // bad operator
      add_row("3", 1'b0, 8'h00);
      add_row("*", 1'b0, 8'h00);
      add_row("8", 1'b0, 8'h00);                     // recovery
      add_row("6", 1'b0, 8'h00);
      add_row("+", 1'b1, calc_result(4'd8, 4'd6, 1'b0));
      for (int k = 0; k < 4; k++) begin
         a = 4'($random(seed));
         b = 4'($random(seed));
         add_row({4'h3, a}, 1'b0, 8'h00);
         add_row({4'h3, b}, 1'b0, 8'h00);
         add_row(k[0] ? "-" : "+", 1'b1, calc_result(a, b, k[0]));
      end
      timeout_limit = num_rows * 3 * uart_pkg::FRAME_BITS * CLKS_PER_BIT + 200;

      repeat (5) @(posedge CLKOP);
      i_rst <= 1'b0;

      // idle line after reset
      errs_before = error_cnt;
      repeat (32) begin
         @(posedge CLKOP);
         compare_value("o_serial_data", 8'h01, {7'b0, o_serial_data});
         compare_value("o_tx_busy", 8'h00, {7'b0, o_tx_busy});
         compare_value("o_result_valid", 8'h00, {7'b0, o_result_valid});
      end
      record_test("idle after reset", errs_before);

      for (int i = 0; i < num_rows; i++) begin
         errs_before = error_cnt;
         @(posedge CLKOP);
         i_rx_valid <= 1'b1;
         i_rx_data  <= row_char[i];
         @(posedge CLKOP);
         i_rx_valid <= 1'b0;
         gap = is_operator(row_char[i]) ? 2 * BYTE_GAP : BYTE_GAP;
         repeat (gap - 1) @(posedge CLKOP);
         expect_serial(row_char[i]);                 // echo first
         if (row_has_res[i]) begin
            expect_serial(row_res[i]);               // then the result char
            expect_result(row_res[i]);
         end
         assert (serial_q.size() == 0) else begin
            $display("extra byte decoded from the serial line");
            error_cnt++;
         end
         assert (result_q.size() == 0) else begin
            $display("unexpected o_result_valid pulse");
            error_cnt++;
         end
         record_test($sformatf("row %0d char %02h", i, row_char[i]), errs_before);
      end

      $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && error_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* rtl/baud_timer.sv */
// bit period timer with a restartable down counter
`timescale 1ns/1ps

module baud_timer #(
   parameter int CLKS_PER_BIT = 16   // 2 or more
) (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_restart,    // realign to a new frame
   output logic o_bit_tick    // last cycle of each bit period
);

   localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
   localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLKS_PER_BIT - 1);

   logic [CNT_W-1:0] cnt;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cnt <= RELOAD;
      end else if (i_restart || (cnt == '0)) begin
         cnt <= RELOAD;          // reload on restart and on every tick
      end else begin
         cnt <= cnt - 1'b1;
      end
   end

   // first tick CLKS_PER_BIT cycles after restart
   assign o_bit_tick = (cnt == '0);

endmodule

/* rtl/calc_if.sv */
// operation request from the character parser to the nibble alu
`timescale 1ns/1ps

interface calc_if;

   logic                                start;   // one cycle strobe
   calc_pkg::calc_op_e                  op;      // add or sub
   logic [calc_pkg::NIBBLE_W-1:0]       r1;      // first operand
   logic [calc_pkg::NIBBLE_W-1:0]       r2;      // second operand

   // op, r1, r2 only meaningful while start is high
   modport source (output start, output op, output r1, output r2);
   modport sink   (input  start, input  op, input  r1, input  r2);

endinterface

/* rtl/calc_pkg.sv */
// calculator package with character codes, operand widths and parser/alu enums

package calc_pkg;

   // ----------------------------------------------------------------------
   // widths
   // ----------------------------------------------------------------------
   localparam int NIBBLE_W = 4;        // operand width
   localparam int CHAR_W   = 8;        // one ascii byte

   // ----------------------------------------------------------------------
   // character codes
   // ----------------------------------------------------------------------
   // digits are 0x30..0x3f, operand is the low nibble
   localparam logic [CHAR_W-NIBBLE_W-1:0] DIGIT_HI = 4'h3;

   localparam logic [CHAR_W-1:0] CHAR_PLUS  = 8'h2B;   // '+'
   localparam logic [CHAR_W-1:0] CHAR_MINUS = 8'h2D;   // '-'
   localparam logic [CHAR_W-1:0] CHAR_ESC   = 8'h1B;   // sequence abort

   // result char is 010 + carry + sum, so '@' .. '_'
   localparam logic [2:0] RESULT_HI = 3'b010;

   // ----------------------------------------------------------------------
   // enums
   // ----------------------------------------------------------------------
   typedef enum logic {
      OP_ADD = 1'b0,
      OP_SUB = 1'b1
   } calc_op_e;

   // parser position in the digit, digit, operator sequence
   typedef enum logic [1:0] {
      ST_FIRST  = 2'd0,   // waiting for r1
      ST_SECOND = 2'd1,   // waiting for r2
      ST_OPER   = 2'd2    // waiting for '+' or '-'
   } parse_state_e;

endpackage

/* rtl/calc_uart_top.sv */
// calculator top level from decoded rx bytes to a serial echo and result stream
`timescale 1ns/1ps

module calc_uart_top #(
   parameter int CLKS_PER_BIT = 16   // serial bit period in CLKOP cycles
) (
   input  logic                        CLKOP,
   input  logic                        i_rst,
   input  logic                        i_rx_valid,
   input  logic [calc_pkg::CHAR_W-1:0] i_rx_data,
   output logic                        o_serial_data,
   output logic                        o_tx_busy,
   output logic                        o_result_valid,   // 2 cycles after operator
   output logic [calc_pkg::CHAR_W-1:0] o_result_char
);

   // ----------------------------------------------------------------------
   // internal connections
   // ----------------------------------------------------------------------
   calc_if u_calc_if ();                      // parser to alu

   logic                        tx_start;
   logic [calc_pkg::CHAR_W-1:0] tx_byte;

   char_parser_fsm u_parser (
      .i_clk      (CLKOP),
      .i_rst      (i_rst),
      .i_rx_valid (i_rx_valid),
      .i_rx_data  (i_rx_data),
      .o_req      (u_calc_if.source)
   );

   nibble_alu u_alu (
      .i_clk       (CLKOP),
      .i_rst       (i_rst),
      .i_req       (u_calc_if.sink),
      .o_res_valid (o_result_valid),
      .o_res_char  (o_result_char)
   );

   // echo first, result queued behind it
   echo_tx_arbiter u_arbiter (
      .i_clk       (CLKOP),
      .i_rst       (i_rst),
      .i_rx_valid  (i_rx_valid),
      .i_rx_data   (i_rx_data),
      .i_res_valid (o_result_valid),
      .i_res_char  (o_result_char),
      .i_tx_busy   (o_tx_busy),
      .o_tx_start  (tx_start),
      .o_tx_byte   (tx_byte)
   );

   uart_tx_serializer #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_tx (
      .i_clk         (CLKOP),
      .i_rst         (i_rst),
      .i_tx_start    (tx_start),
      .i_tx_byte     (tx_byte),
      .o_tx_busy     (o_tx_busy),
      .o_serial_data (o_serial_data)
   );

endmodule

/* rtl/char_parser_fsm.sv */
// character parser that collects two digits and an operator and requests an alu op
`timescale 1ns/1ps

module char_parser_fsm (
   input  logic                        i_clk,
   input  logic                        i_rst,
   input  logic                        i_rx_valid,   // byte strobe
   input  logic [calc_pkg::CHAR_W-1:0] i_rx_data,
   calc_if.source                      o_req
);

   calc_pkg::parse_state_e state;

   logic is_digit;
   logic is_plus;
   logic is_minus;
   logic is_esc;

   // ----------------------------------------------------------------------
   // byte classification
   // ----------------------------------------------------------------------
   always_comb begin
      // upper nibble 3 marks a digit
      is_digit = (i_rx_data[calc_pkg::CHAR_W-1:calc_pkg::NIBBLE_W] == calc_pkg::DIGIT_HI);
      is_plus  = (i_rx_data == calc_pkg::CHAR_PLUS);
      is_minus = (i_rx_data == calc_pkg::CHAR_MINUS);
      is_esc   = (i_rx_data == calc_pkg::CHAR_ESC);
   end

   // ----------------------------------------------------------------------
   // sequence state and start strobe
   // ----------------------------------------------------------------------
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state       <= calc_pkg::ST_FIRST;
         o_req.start <= 1'b0;
      end else begin
         o_req.start <= 1'b0;                        // default, strobe lasts one cycle
         if (i_rx_valid) begin
            if (is_esc) begin
               state <= calc_pkg::ST_FIRST;          // abort, nothing emitted
            end else begin
               case (state)
                  calc_pkg::ST_FIRST:
                     state <= is_digit ? calc_pkg::ST_SECOND : calc_pkg::ST_FIRST;
                  calc_pkg::ST_SECOND:
                     state <= is_digit ? calc_pkg::ST_OPER : calc_pkg::ST_FIRST;
                  calc_pkg::ST_OPER: begin
                     o_req.start <= is_plus | is_minus;
                     state       <= calc_pkg::ST_FIRST;   // any byte ends the sequence
                  end
                  default:
                     state <= calc_pkg::ST_FIRST;
               endcase
            end
         end
      end
   end

   // operand and opcode capture
   always_ff @(posedge i_clk) begin
      if (i_rx_valid && is_digit && (state == calc_pkg::ST_FIRST)) begin
         o_req.r1 <= i_rx_data[calc_pkg::NIBBLE_W-1:0];
      end
      if (i_rx_valid && is_digit && (state == calc_pkg::ST_SECOND)) begin
         o_req.r2 <= i_rx_data[calc_pkg::NIBBLE_W-1:0];
      end
      if (i_rx_valid && (state == calc_pkg::ST_OPER)) begin
         o_req.op <= is_minus ? calc_pkg::OP_SUB : calc_pkg::OP_ADD;
      end
   end

endmodule

/* rtl/echo_tx_arbiter.sv */
// transmit arbiter that echoes each rx byte and queues one alu result behind it
`timescale 1ns/1ps

module echo_tx_arbiter (
   input  logic                        i_clk,
   input  logic                        i_rst,
   input  logic                        i_rx_valid,   // echo request
   input  logic [calc_pkg::CHAR_W-1:0] i_rx_data,
   input  logic                        i_res_valid,  // result request
   input  logic [calc_pkg::CHAR_W-1:0] i_res_char,
   input  logic                        i_tx_busy,
   output logic                        o_tx_start,
   output logic [calc_pkg::CHAR_W-1:0] o_tx_byte
);

   logic                        pend_q;      // result waiting for the line
   logic [calc_pkg::CHAR_W-1:0] pend_char;
   logic                        issue;

   // send pending result once the serializer is idle
   // o_tx_start high means busy has not risen yet, so hold off that cycle too
   assign issue = pend_q & ~i_tx_busy & ~o_tx_start & ~i_rx_valid;

   // ----------------------------------------------------------------------
   // control
   // ----------------------------------------------------------------------
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pend_q     <= 1'b0;
         o_tx_start <= 1'b0;
      end else begin
         o_tx_start <= i_rx_valid | issue;   // echo goes out right away
         if (i_res_valid) begin
            pend_q <= 1'b1;
         end else if (issue) begin
            pend_q <= 1'b0;                  // handed to serializer
         end
      end
   end

   // ----------------------------------------------------------------------
   // data
   // ----------------------------------------------------------------------
   always_ff @(posedge i_clk) begin
      if (i_res_valid) begin
         pend_char <= i_res_char;
      end
      if (i_rx_valid) begin
         o_tx_byte <= i_rx_data;             // echo wins
      end else if (issue) begin
         o_tx_byte <= pend_char;
      end
   end

endmodule

/* rtl/nibble_alu.sv */
// 4-bit add/subtract with carry, result packed into a printable character
`timescale 1ns/1ps

module nibble_alu (
   input  logic                        i_clk,
   input  logic                        i_rst,
   calc_if.sink                        i_req,
   output logic                        o_res_valid,   // one cycle strobe
   output logic [calc_pkg::CHAR_W-1:0] o_res_char
);

   logic [calc_pkg::NIBBLE_W-1:0] opb;      // r2 or its inverse
   logic                          sub_cin;  // +1 for two's complement
   logic [calc_pkg::NIBBLE_W:0]   sum;      // carry & 4-bit sum
   logic [calc_pkg::NIBBLE_W:0]   res_q;

   // r1 + r2, or r1 + ~r2 + 1
   always_comb begin
      sub_cin = (i_req.op == calc_pkg::OP_SUB);
      opb     = sub_cin ? ~i_req.r2 : i_req.r2;
      sum     = {1'b0, i_req.r1} + {1'b0, opb} + {{calc_pkg::NIBBLE_W{1'b0}}, sub_cin};
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_res_valid <= 1'b0;
      end else begin
         o_res_valid <= i_req.start;   // result one cycle after start
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_req.start) begin
         res_q <= sum;                 // for sub, carry high means no borrow
      end
   end

   // '@' .. '_'
   assign o_res_char = {calc_pkg::RESULT_HI, res_q};

endmodule

/* rtl/uart_pkg.sv */
// serial transmit package with 8N1 frame size and transmitter states

package uart_pkg;

   // start + 8 data + stop
   localparam int FRAME_BITS = 10;

   // one state per part of the frame
   typedef enum logic [1:0] {
      TX_IDLE  = 2'd0,   // line high, waiting for a start strobe
      TX_START = 2'd1,   // start bit, line low
      TX_DATA  = 2'd2,   // data bits lsb first
      TX_STOP  = 2'd3    // stop bit, line high
   } tx_state_e;

endpackage

/* rtl/uart_tx_serializer.sv */
// 8N1 serial transmitter, one frame per start strobe
`timescale 1ns/1ps

module uart_tx_serializer #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic                        i_clk,
   input  logic                        i_rst,
   input  logic                        i_tx_start,   // ignored while busy
   input  logic [calc_pkg::CHAR_W-1:0] i_tx_byte,
   output logic                        o_tx_busy,
   output logic                        o_serial_data
);

   localparam int DATA_BITS = uart_pkg::FRAME_BITS - 2;   // minus start and stop
   localparam int BIT_CNT_W = $clog2(DATA_BITS);
   localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(DATA_BITS - 1);

   uart_pkg::tx_state_e         state;
   logic [calc_pkg::CHAR_W-1:0] shift_q;
   logic [BIT_CNT_W-1:0]        bit_cnt;   // data bits already on the line
   logic                        restart;
   logic                        bit_tick;

   assign restart   = i_tx_start & (state == uart_pkg::TX_IDLE);
   assign o_tx_busy = (state != uart_pkg::TX_IDLE);   // high from cycle after start

   baud_timer #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_baud_timer (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_restart  (restart),
      .o_bit_tick (bit_tick)
   );

   // ----------------------------------------------------------------------
   // frame sequencer
   // ----------------------------------------------------------------------
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state         <= uart_pkg::TX_IDLE;
         o_serial_data <= 1'b1;                    // line idle
         bit_cnt       <= '0;
      end else begin
         case (state)
            uart_pkg::TX_IDLE: begin
               if (i_tx_start) begin
                  o_serial_data <= 1'b0;           // start bit
                  bit_cnt       <= '0;
                  state         <= uart_pkg::TX_START;
               end
            end
            uart_pkg::TX_START: begin
               if (bit_tick) begin
                  o_serial_data <= shift_q[0];     // lsb first
                  state         <= uart_pkg::TX_DATA;
               end
            end
            uart_pkg::TX_DATA: begin
               if (bit_tick) begin
                  if (bit_cnt == LAST_BIT) begin
                     o_serial_data <= 1'b1;        // stop bit
                     state         <= uart_pkg::TX_STOP;
                  end else begin
                     o_serial_data <= shift_q[0];
                     bit_cnt       <= bit_cnt + 1'b1;
                  end
               end
            end
            uart_pkg::TX_STOP: begin
               if (bit_tick) begin
                  state <= uart_pkg::TX_IDLE;      // end of frame
               end
            end
            default: state <= uart_pkg::TX_IDLE;
         endcase
      end
   end

   // shift register, next data bit always in bit 0
   always_ff @(posedge i_clk) begin
      if (restart) begin
         shift_q <= i_tx_byte;
      end else if (bit_tick && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA)) begin
         shift_q <= {1'b0, shift_q[calc_pkg::CHAR_W-1:1]};
      end
   end

endmodule

/* sim.f */
rtl/calc_pkg.sv
rtl/uart_pkg.sv
rtl/calc_if.sv
rtl/char_parser_fsm.sv
rtl/nibble_alu.sv
rtl/echo_tx_arbiter.sv
rtl/baud_timer.sv
rtl/uart_tx_serializer.sv
rtl/calc_uart_top.sv
bench/tb_calc_uart.sv
